// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_eth_mac
FILELIST   := eth_mac.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: eth_mac.f
+incdir+test
hdl/eth_mac_pkg.sv
hdl/fifo_if.sv
hdl/crc32.sv
hdl/payload_fifo.sv
hdl/frame_tx.sv
hdl/frame_rx.sv
hdl/eth_mac.sv
test/tb_eth_mac.sv

// File: hdl/crc32.sv
`timescale 1ns/10ps
`default_nettype none

module crc32
  import eth_mac_pkg::*;
(
  input  wire        clk,
  input  wire        fsm_rst,
  input  wire        clr,
  input  wire        en,
  input  wire byte_t d,
  output crc_t       crc,
  output logic       ok
);

  crc_t crc_nxt;

  // one byte, lsb first
  function automatic crc_t crc_byte(input crc_t c, input byte_t b);
    crc_t r;
    r = c ^ {24'h00_0000, b};
    for (int i = 0; i < 8; i++) begin
      r = r[0] ? ((r >> 1) ^ CRC_POLY) : (r >> 1);
    end
    return r;
  endfunction

  assign crc_nxt = crc_byte(crc, d);

  always_ff @(posedge clk) begin
    if (fsm_rst || clr) begin
      crc <= '1;
    end else if (en) begin
      crc <= crc_nxt;
    end
  end

  // residue after data plus complemented fcs
  assign ok = (crc == CRC_RESIDUE);

endmodule

`default_nettype wire

// File: hdl/eth_mac.sv
`timescale 1ns/10ps
`default_nettype none

module eth_mac
  import eth_mac_pkg::*;
(
  input  wire             clk,
  input  wire             fsm_rst,
  input  wire             wr_v,
  input  wire byte_t      wr_d,
  output logic            wr_full,
  input  wire             send,
  input  wire mac_addr_t  tx_dst,
  input  wire ethertype_t tx_type,
  output logic            rdy,
  input  wire mac_addr_t  own_addr,
  output logic            phy_tx_v,
  output byte_t           phy_tx_d,
  input  wire             phy_rx_v,
  input  wire byte_t      phy_rx_d,
  output logic            rx_v,
  output byte_t           rx_d,
  output logic            rx_sof,
  output logic            rx_eof,
  output logic            rx_err,
  output mac_addr_t       rx_dst,
  output mac_addr_t       rx_src,
  output ethertype_t      rx_type,
  output frame_len_t      rx_len
);

  fifo_if fifo_bus ();

  // host write side
  assign fifo_bus.w_v = wr_v;
  assign fifo_bus.w_d = wr_d;
  assign wr_full      = fifo_bus.full;

  payload_fifo payload_fifo_i (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .fifo    (fifo_bus.buffer)
  );

  frame_tx frame_tx_i (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .fifo     (fifo_bus.reader),
    .send     (send),
    .dst      (tx_dst),
    .etype    (tx_type),
    .own_addr (own_addr),
    .rdy      (rdy),
    .phy_v    (phy_tx_v),
    .phy_d    (phy_tx_d)
  );

  frame_rx frame_rx_i (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .own_addr (own_addr),
    .phy_v    (phy_rx_v),
    .phy_d    (phy_rx_d),
    .v        (rx_v),
    .d        (rx_d),
    .sof      (rx_sof),
    .eof      (rx_eof),
    .err      (rx_err),
    .dst      (rx_dst),
    .src      (rx_src),
    .etype    (rx_type),
    .len      (rx_len)
  );

endmodule

`default_nettype wire

// File: hdl/eth_mac_pkg.sv
`default_nettype none

package eth_mac_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [47:0] mac_addr_t;
  typedef logic [15:0] ethertype_t;
  typedef logic [15:0] frame_len_t;
  typedef logic [31:0] crc_t;

  // payload buffer, depth must stay a power of two
  localparam int FIFO_DEPTH = 64;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

  localparam int    PREAMBLE_LEN  = 7;
  localparam byte_t PREAMBLE_BYTE = 8'h55;
  localparam byte_t SFD_BYTE      = 8'hD5;
  localparam int    HDR_LEN       = 14;
  localparam int    MIN_PAYLOAD   = 46;
  localparam int    FCS_LEN       = 4;

  // reflected polynomial, register kept uncomplemented
  localparam crc_t      CRC_POLY       = 32'hEDB8_8320;
  localparam crc_t      CRC_RESIDUE    = 32'hDEBB_20E3;
  localparam mac_addr_t BROADCAST_ADDR = '1;

  typedef enum logic [3:0] {
    idle_s,
    pre_s,
    sfd_s,
    dst_s,
    src_s,
    type_s,
    payload_s,
    pad_s,
    fcs_s
  } tx_state_t;

  typedef enum logic [1:0] {
    hunt_s,
    hdr_s,
    body_s,
    drop_s
  } rx_state_t;

endpackage

`default_nettype wire

// File: hdl/fifo_if.sv
`timescale 1ns/10ps
`default_nettype none

interface fifo_if
  import eth_mac_pkg::*;
();

  logic  w_v;
  byte_t w_d;
  logic  full;
  logic  r_v;
  byte_t r_q;
  logic  empty;

  modport writer (output w_v, w_d, input full);

  modport buffer (input w_v, w_d, r_v, output full, empty, r_q);

  // r_q is the head byte, r_v pops it
  modport reader (output r_v, input r_q, empty);

endinterface

`default_nettype wire

// File: hdl/frame_rx.sv
`timescale 1ns/10ps
`default_nettype none

module frame_rx
  import eth_mac_pkg::*;
(
  input  wire            clk,
  input  wire            fsm_rst,
  input  wire mac_addr_t own_addr,
  input  wire            phy_v,
  input  wire byte_t     phy_d,
  output logic           v,
  output byte_t          d,
  output logic           sof,
  output logic           eof,
  output logic           err,
  output mac_addr_t      dst,
  output mac_addr_t      src,
  output ethertype_t     etype,
  output frame_len_t     len
);

  rx_state_t                state;
  logic                     pre_seen;
  logic [3:0]               hdr_cnt;
  logic [2:0]               fill;
  logic                     started;
  logic [8*(HDR_LEN-1)-1:0] hdr_sh;
  // fcs window plus the byte held back for eof
  byte_t [FCS_LEN:0]        dly;
  mac_addr_t                hdr_dst;
  // set by a sof pulse on the output, cleared by eof
  logic                     in_frame;

  logic crc_clr;
  logic crc_en;
  logic crc_ok;
  logic hdr_last;
  logic accept;
  logic body_byte;
  logic push_out;
  logic end_now;
  logic eof_now;

  crc32 crc_i (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .clr     (crc_clr),
    .en      (crc_en),
    .d       (phy_d),
    .crc     (),
    .ok      (crc_ok)
  );

  assign crc_clr = (state == hunt_s);
  assign crc_en  = phy_v && ((state == hdr_s) || (state == body_s));

  assign hdr_dst   = hdr_sh[8*(HDR_LEN-1)-1 -: 48];
  assign hdr_last  = (state == hdr_s) && phy_v && (hdr_cnt == 4'(HDR_LEN - 1));
  assign accept    = (hdr_dst == own_addr) || (hdr_dst == BROADCAST_ADDR);
  assign body_byte = (state == body_s) && phy_v;
  assign push_out  = body_byte && (fill == 3'(FCS_LEN + 1));
  assign end_now   = (state == body_s) && !phy_v;
  assign eof_now   = end_now && started && (fill == 3'(FCS_LEN + 1));

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state    <= hunt_s;
      pre_seen <= 1'b0;
      hdr_cnt  <= '0;
      fill     <= '0;
      started  <= 1'b0;
      in_frame <= 1'b0;
      v        <= 1'b0;
      sof      <= 1'b0;
      eof      <= 1'b0;
      err      <= 1'b0;
    end else begin
      v   <= push_out || eof_now;
      sof <= push_out && !started;
      eof <= eof_now;
      err <= eof_now && !crc_ok;
      if (sof) begin
        in_frame <= 1'b1;
      end
      if (eof) begin
        in_frame <= 1'b0;
      end
      case (state)
        hunt_s: begin
          pre_seen <= phy_v && (phy_d == PREAMBLE_BYTE);
          hdr_cnt  <= '0;
          if (phy_v && (phy_d == SFD_BYTE) && pre_seen) begin
            state <= hdr_s;
          end
        end
        hdr_s: begin
          if (!phy_v) begin
            // runt
            state <= hunt_s;
          end else begin
            hdr_cnt <= hdr_cnt + 4'd1;
            if (hdr_last) begin
              fill    <= '0;
              started <= 1'b0;
              state   <= accept ? body_s : drop_s;
            end
          end
        end
        body_s: begin
          if (push_out) begin
            started <= 1'b1;
          end
          if (body_byte && (fill != 3'(FCS_LEN + 1))) begin
            fill <= fill + 3'd1;
          end
          if (end_now) begin
            state <= hunt_s;
          end
        end
        drop_s: begin
          if (!phy_v) begin
            state <= hunt_s;
          end
        end
        default: state <= hunt_s;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == hdr_s) && phy_v) begin
      hdr_sh <= {hdr_sh[8*(HDR_LEN-2)-1:0], phy_d};
    end
    if (hdr_last && accept) begin
      dst   <= hdr_dst;
      src   <= hdr_sh[8*(HDR_LEN-7)-1 -: 48];
      etype <= {hdr_sh[7:0], phy_d};
    end
    if (body_byte) begin
      dly <= {dly[FCS_LEN-1:0], phy_d};
    end
    if (push_out || eof_now) begin
      d   <= dly[FCS_LEN];
      len <= started ? (len + 16'd1) : 16'd1;
    end
  end

  a_eof_after_sof: assert property (
    @(posedge clk) disable iff (fsm_rst)
    eof |-> in_frame
  );

endmodule

`default_nettype wire

// File: hdl/frame_tx.sv
`timescale 1ns/10ps
`default_nettype none

module frame_tx
  import eth_mac_pkg::*;
(
  input  wire             clk,
  input  wire             fsm_rst,
  fifo_if.reader          fifo,
  input  wire             send,
  input  wire mac_addr_t  dst,
  input  wire ethertype_t etype,
  input  wire mac_addr_t  own_addr,
  output logic            rdy,
  output logic            phy_v,
  output byte_t           phy_d
);

  tx_state_t  state;
  logic [2:0] byte_cnt;
  frame_len_t len;
  mac_addr_t  dst_sh;
  mac_addr_t  src_sh;
  ethertype_t type_sh;

  // first stage, one slot per wire byte
  logic       v_s1;
  byte_t      d_s1;
  logic       crc_s1;
  logic       fcs_s1;
  logic [1:0] fcs_idx_s1;

  crc_t       crc_val;
  crc_t       fcs_val;
  logic       crc_clr;

  assign fifo.r_v = (state == payload_s) && !fifo.empty;
  assign crc_clr  = (state == idle_s);
  assign fcs_val  = ~crc_val;

  crc32 crc_i (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .clr     (crc_clr),
    .en      (crc_s1),
    .d       (d_s1),
    .crc     (crc_val),
    .ok      ()
  );

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state    <= idle_s;
      byte_cnt <= '0;
      len      <= '0;
      rdy      <= 1'b1;
      v_s1     <= 1'b0;
      crc_s1   <= 1'b0;
      fcs_s1   <= 1'b0;
      phy_v    <= 1'b0;
    end else begin
      phy_v  <= v_s1;
      v_s1   <= 1'b0;
      crc_s1 <= 1'b0;
      fcs_s1 <= 1'b0;
      case (state)
        idle_s: begin
          // one quiet cycle on the wire before ready
          if (!rdy) begin
            rdy <= !v_s1 && !phy_v;
          end else if (send) begin
            rdy      <= 1'b0;
            byte_cnt <= '0;
            state    <= pre_s;
          end
        end
        pre_s: begin
          v_s1     <= 1'b1;
          byte_cnt <= byte_cnt + 3'd1;
          if (byte_cnt == 3'(PREAMBLE_LEN - 1)) begin
            state <= sfd_s;
          end
        end
        sfd_s: begin
          v_s1     <= 1'b1;
          byte_cnt <= '0;
          state    <= dst_s;
        end
        dst_s: begin
          v_s1     <= 1'b1;
          crc_s1   <= 1'b1;
          byte_cnt <= byte_cnt + 3'd1;
          if (byte_cnt == 3'd5) begin
            byte_cnt <= '0;
            state    <= src_s;
          end
        end
        src_s: begin
          v_s1     <= 1'b1;
          crc_s1   <= 1'b1;
          byte_cnt <= byte_cnt + 3'd1;
          if (byte_cnt == 3'd5) begin
            byte_cnt <= '0;
            state    <= type_s;
          end
        end
        type_s: begin
          v_s1     <= 1'b1;
          crc_s1   <= 1'b1;
          byte_cnt <= byte_cnt + 3'd1;
          if (byte_cnt == 3'd1) begin
            len   <= '0;
            state <= payload_s;
          end
        end
        payload_s: begin
          v_s1 <= 1'b1;
          if (!fifo.empty) begin
            crc_s1 <= 1'b1;
            len    <= len + 16'd1;
          end else if (len < frame_len_t'(MIN_PAYLOAD)) begin
            // first pad byte
            crc_s1   <= 1'b1;
            len      <= len + 16'd1;
            byte_cnt <= '0;
            state    <= (len == frame_len_t'(MIN_PAYLOAD - 1)) ? fcs_s : pad_s;
          end else begin
            // long frame, fcs byte 0 fills this slot
            fcs_s1   <= 1'b1;
            byte_cnt <= 3'd1;
            state    <= fcs_s;
          end
        end
        pad_s: begin
          v_s1   <= 1'b1;
          crc_s1 <= 1'b1;
          len    <= len + 16'd1;
          if (len == frame_len_t'(MIN_PAYLOAD - 1)) begin
            byte_cnt <= '0;
            state    <= fcs_s;
          end
        end
        fcs_s: begin
          v_s1     <= 1'b1;
          fcs_s1   <= 1'b1;
          byte_cnt <= byte_cnt + 3'd1;
          if (byte_cnt == 3'(FCS_LEN - 1)) begin
            state <= idle_s;
          end
        end
        default: state <= idle_s;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      idle_s: begin
        if (rdy && send) begin
          dst_sh  <= dst;
          src_sh  <= own_addr;
          type_sh <= etype;
        end
      end
      pre_s: d_s1 <= PREAMBLE_BYTE;
      sfd_s: d_s1 <= SFD_BYTE;
      dst_s: begin
        d_s1   <= dst_sh[47:40];
        dst_sh <= dst_sh << 8;
      end
      src_s: begin
        d_s1   <= src_sh[47:40];
        src_sh <= src_sh << 8;
      end
      type_s: begin
        d_s1    <= type_sh[15:8];
        type_sh <= type_sh << 8;
      end
      payload_s: begin
        d_s1       <= fifo.empty ? 8'h00 : fifo.r_q;
        fcs_idx_s1 <= 2'd0;
      end
      pad_s: d_s1 <= 8'h00;
      fcs_s: fcs_idx_s1 <= byte_cnt[1:0];
      default: d_s1 <= d_s1;
    endcase
    // crc holds its final value by the time fcs slots reach the output
    phy_d <= fcs_s1 ? fcs_val[8 * fcs_idx_s1 +: 8] : d_s1;
  end

  a_payload_no_gap: assert property (
    @(posedge clk) disable iff (fsm_rst)
    (state == payload_s) |=> phy_v
  );

endmodule

`default_nettype wire

// File: hdl/payload_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module payload_fifo
  import eth_mac_pkg::*;
(
  input  wire    clk,
  input  wire    fsm_rst,
  fifo_if.buffer fifo
);

  byte_t              mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;
  logic               push;
  logic               pop;

  // writes while full are dropped
  assign push = fifo.w_v && !fifo.full;
  assign pop  = fifo.r_v && !fifo.empty;

  assign fifo.full  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
  assign fifo.empty = (count == '0);
  assign fifo.r_q   = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= fifo.w_d;
    end
  end

  // reader must not pop an empty buffer
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (fsm_rst)
    fifo.r_v |-> !fifo.empty
  );

  // a write into a full buffer leaves it untouched
  a_no_push_full: assert property (
    @(posedge clk) disable iff (fsm_rst)
    (fifo.w_v && fifo.full && !fifo.r_v) |=> (fifo.full && $stable(wr_ptr))
  );

endmodule

`default_nettype wire

// File: test/frame_table.svh
`ifndef FRAME_TABLE_SVH
`define FRAME_TABLE_SVH

  // columns: name, payload bytes, rng skip, destination, ethertype, flipped byte, accept
  // flipped byte counts from the first destination byte, -1 for a clean frame
  task automatic load_frame_table();
    add_case("short_pad",    10,         0, OWN_ADDR,       16'h0800, -1,               1'b1);
    add_case("long_frame",   60,         3, OWN_ADDR,       16'h86DD, -1,               1'b1);
    add_case("bad_payload",  20,         1, OWN_ADDR,       16'h0800, HDR_LEN + 5,      1'b1);
    add_case("clean_after",  46,         2, OWN_ADDR,       16'h88B5, -1,               1'b1);
    add_case("bad_fcs",      50,         2, OWN_ADDR,       16'h88B5, HDR_LEN + 50 + 2, 1'b1);
    add_case("foreign_dst",  12,         5, FOREIGN_ADDR,   16'h0800, -1,               1'b0);
    add_case("broadcast",    30,         4, BROADCAST_ADDR, 16'h0806, -1,               1'b1);
    add_case("buffer_limit", FIFO_DEPTH, 7, OWN_ADDR,       16'h0800, -1,               1'b1);
  endtask

`endif

// File: test/tb_eth_mac.sv
`timescale 1ns/10ps
`default_nettype none

module tb_eth_mac
  import eth_mac_pkg::*;
();

  localparam mac_addr_t OWN_ADDR     = 48'h02_00_5E_10_20_30;
  localparam mac_addr_t FOREIGN_ADDR = 48'h02_00_5E_10_20_31;
  localparam int        RST_CYCLES   = 16;
  localparam int        ROW_MARGIN   = 40;

  logic       clk = 1'b0;
  logic       fsm_rst;
  logic       wr_v;
  byte_t      wr_d;
  logic       wr_full;
  logic       send;
  mac_addr_t  tx_dst;
  ethertype_t tx_type;
  logic       rdy;
  mac_addr_t  own_addr;
  logic       phy_tx_v;
  byte_t      phy_tx_d;
  logic       phy_rx_v = 1'b0;
  byte_t      phy_rx_d = 8'h00;
  logic       rx_v;
  byte_t      rx_d;
  logic       rx_sof;
  logic       rx_eof;
  logic       rx_err;
  mac_addr_t  rx_dst;
  mac_addr_t  rx_src;
  ethertype_t rx_type;
  frame_len_t rx_len;

  // frame table, one entry per row
  string      name_q[$];
  int         len_q[$];
  int         skip_q[$];
  mac_addr_t  dst_q[$];
  ethertype_t type_q[$];
  int         flip_q[$];
  logic       accept_q[$];

  // receive monitor results, never cleared
  byte_t      got_q[$];
  int         sof_cnt = 0;
  int         eof_cnt = 0;
  logic       got_err;
  frame_len_t got_len;
  mac_addr_t  got_dst;
  mac_addr_t  got_src;
  ethertype_t got_type;

  int flip_idx    = -1;
  int wire_pos    = 0;
  int cycle_cnt   = 0;
  int cycle_limit = 0;

  eth_mac dut_i (.*);

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("timeout: run still busy after %0d cycles", cycle_cnt);
      $display(">>> FAIL");
      $fatal(1, "simulation stopped by cycle limit");
    end
  end

  // loopback, flip_idx counts from the first destination byte
  always @(negedge clk) begin
    phy_rx_v <= phy_tx_v;
    phy_rx_d <= phy_tx_d;
    if (phy_tx_v) begin
      if (flip_idx >= 0 && (wire_pos - PREAMBLE_LEN - 1) == flip_idx) begin
        phy_rx_d <= phy_tx_d ^ 8'h01;
      end
      wire_pos <= wire_pos + 1;
    end else begin
      wire_pos <= 0;
    end
  end

  always @(negedge clk) begin
    if (rx_sof) begin
      sof_cnt  <= sof_cnt + 1;
      got_dst  <= rx_dst;
      got_src  <= rx_src;
      got_type <= rx_type;
    end
    if (rx_v) begin
      got_q.push_back(rx_d);
    end
    if (rx_eof) begin
      eof_cnt <= eof_cnt + 1;
      got_err <= rx_err;
      got_len <= rx_len;
    end
  end

  task automatic check_value(input string what, input logic [63:0] exp,
                             input logic [63:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s: expected %0h, got %0h", what, exp, act);
      $display(">>> FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic add_case(input string name, input int n, input int skip,
                          input mac_addr_t dst, input ethertype_t etype,
                          input int flip, input logic accept);
    name_q.push_back(name);
    len_q.push_back(n);
    skip_q.push_back(skip);
    dst_q.push_back(dst);
    type_q.push_back(etype);
    flip_q.push_back(flip);
    accept_q.push_back(accept);
  endtask

  // preamble, sfd, header, padded payload, fcs
  function automatic int frame_cycles(input int n);
    return PREAMBLE_LEN + 1 + HDR_LEN + ((n > MIN_PAYLOAD) ? n : MIN_PAYLOAD) + FCS_LEN;
  endfunction

  `include "frame_table.svh"

  task automatic run_case(input int idx);
    string name;
    int    n;
    int    pad_len;
    int    flip;
    int    base_sof;
    int    base_eof;
    int    base_bytes;
    int    rise;
    int    high;
    byte_t exp_q[$];
    name    = name_q[idx];
    n       = len_q[idx];
    flip    = flip_q[idx];
    pad_len = (n > MIN_PAYLOAD) ? n : MIN_PAYLOAD;
    // skipped draws give each row its own part of the sequence
    repeat (skip_q[idx]) void'($urandom());
    for (int k = 0; k < n; k++) begin
      exp_q.push_back(byte_t'($urandom()));
    end
    for (int k = 0; k < n; k++) begin
      check_value({name, " wr_full before write"}, 0, wr_full);
      wr_v = 1'b1;
      wr_d = exp_q[k];
      @(negedge clk);
    end
    wr_v = 1'b0;
    if (n == FIFO_DEPTH) begin
      check_value({name, " wr_full at depth"}, 1, wr_full);
      // this byte must never reach the wire
      wr_v = 1'b1;
      wr_d = 8'hEE;
      @(negedge clk);
      wr_v = 1'b0;
      check_value({name, " wr_full after extra write"}, 1, wr_full);
    end
    while (exp_q.size() < pad_len) begin
      exp_q.push_back(8'h00);
    end
    if (flip >= HDR_LEN && flip < HDR_LEN + pad_len) begin
      exp_q[flip - HDR_LEN] = exp_q[flip - HDR_LEN] ^ 8'h01;
    end

    flip_idx   = flip;
    base_sof   = sof_cnt;
    base_eof   = eof_cnt;
    base_bytes = got_q.size();
    tx_dst     = dst_q[idx];
    tx_type    = type_q[idx];
    check_value({name, " rdy before send"}, 1, rdy);
    send = 1'b1;
    @(negedge clk);
    send    = 1'b0;
    tx_dst  = '0;
    tx_type = '0;
    check_value({name, " rdy after send"}, 0, rdy);
    rise = 0;
    while (!phy_tx_v && rise < 8) begin
      @(negedge clk);
      rise++;
    end
    check_value({name, " phy_tx_v rise delay"}, 2, rise);
    high = 0;
    while (phy_tx_v) begin
      check_value({name, " rdy during frame"}, 0, rdy);
      high++;
      @(negedge clk);
    end
    check_value({name, " frame cycles"}, frame_cycles(n), high);
    while (!rdy) begin
      @(negedge clk);
    end

    if (accept_q[idx]) begin
      while (eof_cnt == base_eof) begin
        @(negedge clk);
      end
      check_value({name, " sof count"}, 1, sof_cnt - base_sof);
      check_value({name, " eof count"}, 1, eof_cnt - base_eof);
      check_value({name, " rx_len"}, pad_len, got_len);
      check_value({name, " byte count"}, pad_len, got_q.size() - base_bytes);
      for (int k = 0; k < pad_len; k++) begin
        check_value($sformatf("%s byte %0d", name, k), exp_q[k], got_q[base_bytes + k]);
      end
      check_value({name, " rx_err"}, (flip >= 0), got_err);
      check_value({name, " rx_dst"}, dst_q[idx], got_dst);
      check_value({name, " rx_src"}, OWN_ADDR, got_src);
      check_value({name, " rx_type"}, type_q[idx], got_type);
    end else begin
      repeat (6) @(negedge clk);
      check_value({name, " sof count"}, 0, sof_cnt - base_sof);
      check_value({name, " eof count"}, 0, eof_cnt - base_eof);
      check_value({name, " byte count"}, 0, got_q.size() - base_bytes);
    end
  endtask

  initial begin
    fsm_rst  = 1'b1;
    wr_v     = 1'b0;
    wr_d     = 8'h00;
    send     = 1'b0;
    tx_dst   = '0;
    tx_type  = '0;
    own_addr = OWN_ADDR;
    void'($urandom(17));
    load_frame_table();
    cycle_limit = RST_CYCLES + ROW_MARGIN;
    foreach (len_q[i]) begin
      cycle_limit += len_q[i] + 1 + frame_cycles(len_q[i]) + ROW_MARGIN;
    end

    repeat (RST_CYCLES) @(negedge clk);
    check_value("reset rdy", 1, rdy);
    check_value("reset phy_tx_v", 0, phy_tx_v);
    check_value("reset wr_full", 0, wr_full);
    check_value("reset rx_v", 0, rx_v);
    check_value("reset rx_sof", 0, rx_sof);
    check_value("reset rx_eof", 0, rx_eof);
    check_value("reset rx_err", 0, rx_err);
    fsm_rst = 1'b0;
    @(negedge clk);

    foreach (len_q[i]) begin
      run_case(i);
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire
